// File: verilog/spi_cfg_pkg.sv
package spi_cfg_pkg;

    // Host data words
    localparam int DATA_W = 32;

    localparam int ADDR_W = 32;

    // Opcode width
    localparam int CMD_W = 8;

    // Data length in bits, 0 means no data phase
    localparam int NBITS_W = 7;

    localparam int DUMMY_W = 4;

    // Command, address and write data back to back
    localparam int TXSTR_W = CMD_W + ADDR_W + DATA_W;

    // Serial cycle counters, longest frame stays well below 256
    localparam int CNT_W = 8;

endpackage

// File: verilog/spi_frame_pkg.sv
package spi_frame_pkg;

    localparam int FRAME_KIND_W = 3;

    // Frame kinds
    localparam logic [FRAME_KIND_W-1:0] KIND_CMD      = 3'd0;
    localparam logic [FRAME_KIND_W-1:0] KIND_CMD_WR   = 3'd1;
    localparam logic [FRAME_KIND_W-1:0] KIND_CMD_ADDR = 3'd2;
    localparam logic [FRAME_KIND_W-1:0] KIND_ADDR_RD  = 3'd3;
    localparam logic [FRAME_KIND_W-1:0] KIND_ADDR_WR  = 3'd4;

    localparam int PHASE_W = 3;

    // Phase of the serial cycle on the wire
    localparam logic [PHASE_W-1:0] PH_IDLE    = 3'd0;
    localparam logic [PHASE_W-1:0] PH_CMD     = 3'd1;
    localparam logic [PHASE_W-1:0] PH_ADDR    = 3'd2;
    localparam logic [PHASE_W-1:0] PH_DUMMY   = 3'd3;
    localparam logic [PHASE_W-1:0] PH_DATA_TX = 3'd4;
    localparam logic [PHASE_W-1:0] PH_DATA_RX = 3'd5;

endpackage

// File: verilog/spi_frame_decoder.sv
`timescale 1ns/1ps

module spi_frame_decoder (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 decode_start,
    input  logic [spi_frame_pkg::FRAME_KIND_W-1:0] frame_kind,
    input  logic [spi_cfg_pkg::CMD_W-1:0]        command,
    input  logic [spi_cfg_pkg::ADDR_W-1:0]       address,
    input  logic [spi_cfg_pkg::DATA_W-1:0]       write_data,
    input  logic [spi_cfg_pkg::NBITS_W-1:0]      ndata_bits,
    input  logic [spi_cfg_pkg::DUMMY_W-1:0]      dummy_cycles,
    input  logic                                 addr4_en,
    input  logic                                 quad_en,
    output logic                                 decode_done,
    output logic [spi_cfg_pkg::TXSTR_W-1:0]      tx_str,
    output logic [spi_cfg_pkg::CNT_W-1:0]        cmd_end,
    output logic [spi_cfg_pkg::CNT_W-1:0]        addr_end,
    output logic [spi_cfg_pkg::CNT_W-1:0]        dummy_end,
    output logic [spi_cfg_pkg::CNT_W-1:0]        total_cycles,
    output logic                                 rx_active,
    output logic                                 quad_data
);
    import spi_cfg_pkg::*;
    import spi_frame_pkg::*;

    logic               has_addr;
    logic               has_data;
    logic               is_read;
    logic [CNT_W-1:0]   addr_len;
    logic [CNT_W-1:0]   dummy_len;
    logic [CNT_W-1:0]   data_len;
    logic [TXSTR_W-1:0] str_next;

    always_comb begin
        case (frame_kind)
            KIND_CMD: begin
                has_addr = 1'b0;
                has_data = 1'b0;
            end
            KIND_CMD_WR: begin
                has_addr = 1'b0;
                has_data = 1'b1;
            end
            KIND_CMD_ADDR: begin
                has_addr = 1'b1;
                has_data = 1'b0;
            end
            KIND_ADDR_RD, KIND_ADDR_WR: begin
                has_addr = 1'b1;
                has_data = 1'b1;
            end
            default: begin
                has_addr = 1'b0;
                has_data = 1'b0;
            end
        endcase
        is_read = (frame_kind == KIND_ADDR_RD);
        addr_len = has_addr ? (addr4_en ? CNT_W'(32) : CNT_W'(24)) : '0;
        // Dummy cycles only exist ahead of read data
        dummy_len = is_read ? CNT_W'(dummy_cycles) : '0;
        if (!has_data)
            data_len = '0;
        else if (quad_en)
            data_len = CNT_W'(ndata_bits >> 2);
        else
            data_len = CNT_W'(ndata_bits);
        // Write data follows the address directly, MSB first
        if (!has_addr)
            str_next = {command, write_data, {ADDR_W{1'b0}}};
        else if (addr4_en)
            str_next = {command, address, write_data};
        else
            str_next = {command, address[23:0], write_data, 8'h00};
    end

    always_ff @(posedge clk) begin
        if (decode_start) begin
            tx_str       <= str_next;
            cmd_end      <= CNT_W'(CMD_W);
            addr_end     <= CNT_W'(CMD_W) + addr_len;
            dummy_end    <= CNT_W'(CMD_W) + addr_len + dummy_len;
            total_cycles <= CNT_W'(CMD_W) + addr_len + dummy_len + data_len;
            rx_active    <= is_read;
            quad_data    <= quad_en && has_data;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            decode_done <= 1'b0;
        else
            decode_done <= decode_start;
    end

endmodule

// File: verilog/spi_sclk_gen.sv
`timescale 1ns/1ps

module spi_sclk_gen #(
    parameter int CLKS_PER_HALF_SCLK = 2
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sclk_en,
    input  logic                          xfer_start,
    input  logic [spi_cfg_pkg::CNT_W-1:0] total_cycles,
    output logic                          sclk,
    output logic                          lead_edge,
    output logic                          trail_edge,
    output logic [spi_cfg_pkg::CNT_W-1:0] cycle_count,
    output logic                          xfer_done
);

    localparam int HALF_W = $clog2(CLKS_PER_HALF_SCLK + 1);

    logic [HALF_W-1:0] half_cnt;
    logic              running;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sclk        <= 1'b0;
            lead_edge   <= 1'b0;
            trail_edge  <= 1'b0;
            half_cnt    <= '0;
            cycle_count <= '0;
            running     <= 1'b0;
            xfer_done   <= 1'b0;
        end else begin
            lead_edge  <= 1'b0;
            trail_edge <= 1'b0;
            xfer_done  <= 1'b0;
            if (xfer_start) begin
                running     <= 1'b1;
                sclk        <= 1'b0;
                half_cnt    <= '0;
                cycle_count <= '0;
            end else if (!sclk_en) begin
                running  <= 1'b0;
                sclk     <= 1'b0;
                half_cnt <= '0;
            end else if (running) begin
                if (cycle_count == total_cycles) begin
                    // Last falling edge already seen
                    running   <= 1'b0;
                    xfer_done <= 1'b1;
                end else if (half_cnt == HALF_W'(CLKS_PER_HALF_SCLK - 1)) begin
                    half_cnt   <= '0;
                    sclk       <= ~sclk;
                    lead_edge  <= ~sclk;
                    trail_edge <= sclk;
                    if (sclk)
                        cycle_count <= cycle_count + 1'b1;
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end
        end
    end

endmodule

// File: verilog/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              xfer_start,
    input  logic                              lead_edge,
    input  logic                              trail_edge,
    input  logic [spi_cfg_pkg::CNT_W-1:0]     cycle_count,
    input  logic [spi_cfg_pkg::TXSTR_W-1:0]   tx_str,
    input  logic [spi_cfg_pkg::CNT_W-1:0]     cmd_end,
    input  logic [spi_cfg_pkg::CNT_W-1:0]     addr_end,
    input  logic [spi_cfg_pkg::CNT_W-1:0]     dummy_end,
    input  logic                              quad_data,
    input  logic                              rx_active,
    input  logic [3:0]                        dq_in,
    output logic [3:0]                        dq_out,
    output logic [3:0]                        dq_oe,
    output logic [2*spi_cfg_pkg::DATA_W-1:0]  rx_bits
);
    import spi_cfg_pkg::*;
    import spi_frame_pkg::*;

    localparam int RX_W = 2 * DATA_W;

    logic [TXSTR_W-1:0] tx_sr;
    logic [PHASE_W-1:0] cur_phase;
    logic [PHASE_W-1:0] next_phase;
    logic               quad_tx;
    logic               drives_bit;

    // Phase of the serial cycle that cycle_count points at
    always_comb begin
        if (cycle_count < cmd_end)
            next_phase = PH_CMD;
        else if (cycle_count < addr_end)
            next_phase = PH_ADDR;
        else if (cycle_count < dummy_end)
            next_phase = PH_DUMMY;
        else if (rx_active)
            next_phase = PH_DATA_RX;
        else
            next_phase = PH_DATA_TX;
        quad_tx = quad_data && (next_phase == PH_DATA_TX);
        drives_bit = (next_phase == PH_CMD) || (next_phase == PH_ADDR) ||
                     (next_phase == PH_DATA_TX);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_phase <= PH_IDLE;
            dq_out    <= 4'b0000;
        end else if (xfer_start) begin
            // First command bit must be set up before the first rising edge
            cur_phase <= PH_CMD;
            dq_out    <= {3'b000, tx_str[TXSTR_W-1]};
        end else if (trail_edge) begin
            cur_phase <= next_phase;
            if (quad_tx)
                dq_out <= tx_sr[TXSTR_W-1 -: 4];
            else if (drives_bit)
                dq_out <= {3'b000, tx_sr[TXSTR_W-1]};
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_start)
            tx_sr <= tx_str << 1;
        else if (trail_edge && quad_tx)
            tx_sr <= tx_sr << 4;
        else if (trail_edge && drives_bit)
            tx_sr <= tx_sr << 1;
    end

    // Flash drives on falling edges, so sample on rising ones
    always_ff @(posedge clk) begin
        if (xfer_start)
            rx_bits <= '0;
        else if (lead_edge && cur_phase == PH_DATA_RX) begin
            if (quad_data)
                rx_bits <= {rx_bits[RX_W-5:0], dq_in};
            else
                rx_bits <= {rx_bits[RX_W-2:0], dq_in[1]};
        end
    end

    always_comb begin
        case (cur_phase)
            PH_CMD, PH_ADDR: dq_oe = 4'b0001;
            PH_DATA_TX:      dq_oe = quad_data ? 4'b1111 : 4'b0001;
            // Dummy and read phases leave the bus to the flash
            default:         dq_oe = 4'b0000;
        endcase
    end

endmodule

// File: verilog/spi_read_collector.sv
`timescale 1ns/1ps

module spi_read_collector (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             xfer_done,
    input  logic                             rx_active,
    input  logic [spi_cfg_pkg::NBITS_W-1:0]  ndata_bits,
    input  logic [2*spi_cfg_pkg::DATA_W-1:0] rx_bits,
    output logic [spi_cfg_pkg::DATA_W-1:0]   read_data
);
    import spi_cfg_pkg::*;

    logic [NBITS_W-1:0] pad_bits;
    logic [DATA_W-1:0]  aligned;
    logic [DATA_W-1:0]  swapped;

    always_comb begin
        // Push the first received byte up to the top of the word
        if (ndata_bits >= NBITS_W'(DATA_W))
            pad_bits = '0;
        else
            pad_bits = NBITS_W'(DATA_W) - ndata_bits;
        aligned = rx_bits[DATA_W-1:0] << pad_bits;
        for (int i = 0; i < DATA_W / 8; i++) begin
            swapped[8*i +: 8] = aligned[DATA_W-1-8*i -: 8];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            read_data <= '0;
        else if (xfer_done && rx_active)
            read_data <= swapped;
    end

endmodule

// File: verilog/spi_flash_master.sv
`timescale 1ns/1ps

module spi_flash_master #(
    parameter int CLKS_PER_HALF_SCLK = 2
) (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic                                   valid,
    output logic                                   tready,
    input  logic [spi_frame_pkg::FRAME_KIND_W-1:0] frame_kind,
    input  logic [spi_cfg_pkg::CMD_W-1:0]          command,
    input  logic [spi_cfg_pkg::ADDR_W-1:0]         address,
    input  logic [spi_cfg_pkg::DATA_W-1:0]         write_data,
    input  logic [spi_cfg_pkg::NBITS_W-1:0]        ndata_bits,
    input  logic [spi_cfg_pkg::DUMMY_W-1:0]        dummy_cycles,
    input  logic                                   addr4_en,
    input  logic                                   quad_en,
    output logic [spi_cfg_pkg::DATA_W-1:0]         read_data,
    output logic                                   done,
    output logic                                   sclk,
    output logic                                   ss_n,
    output logic [3:0]                             dq_out,
    output logic [3:0]                             dq_oe,
    input  logic [3:0]                             dq_in
);
    import spi_cfg_pkg::*;
    import spi_frame_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_SETUP, ST_XFER} state_t;

    state_t                  state;
    logic [FRAME_KIND_W-1:0] req_kind;
    logic [CMD_W-1:0]        req_command;
    logic [ADDR_W-1:0]       req_address;
    logic [DATA_W-1:0]       req_wdata;
    logic [NBITS_W-1:0]      req_nbits;
    logic [DUMMY_W-1:0]      req_dummy;
    logic                    req_addr4;
    logic                    req_quad;
    logic                    decode_start, decode_done;
    logic [TXSTR_W-1:0]      tx_str;
    logic [CNT_W-1:0]        cmd_end, addr_end, dummy_end, total_cycles;
    logic                    rx_active, quad_data;
    logic                    xfer_start, sclk_en, xfer_done;
    logic                    lead_edge, trail_edge;
    logic [CNT_W-1:0]        cycle_count;
    logic [2*DATA_W-1:0]     rx_bits;
    logic [3:0]              lane_oe;

    always_ff @(posedge clk) begin
        if (valid && tready) begin
            req_kind    <= frame_kind;
            req_command <= command;
            req_address <= address;
            req_wdata   <= write_data;
            req_nbits   <= ndata_bits;
            req_dummy   <= dummy_cycles;
            req_addr4   <= addr4_en;
            req_quad    <= quad_en;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= ST_IDLE;
            tready       <= 1'b1;
            ss_n         <= 1'b1;
            decode_start <= 1'b0;
            xfer_start   <= 1'b0;
            sclk_en      <= 1'b0;
            done         <= 1'b0;
        end else begin
            decode_start <= 1'b0;
            xfer_start   <= 1'b0;
            done         <= 1'b0;
            case (state)
                ST_IDLE: if (valid && tready) begin
                    tready       <= 1'b0;
                    decode_start <= 1'b1;
                    state        <= ST_SETUP;
                end
                ST_SETUP: if (decode_done) begin
                    ss_n       <= 1'b0;
                    xfer_start <= 1'b1;
                    sclk_en    <= 1'b1;
                    state      <= ST_XFER;
                end
                ST_XFER: if (xfer_done) begin
                    ss_n    <= 1'b1;
                    sclk_en <= 1'b0;
                    tready  <= 1'b1;
                    done    <= 1'b1;
                    state   <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Lanes released while the flash is deselected
    assign dq_oe = ss_n ? 4'b0000 : lane_oe;

    spi_frame_decoder decoder_i (
        .clk(clk), .rst(rst), .decode_start(decode_start), .frame_kind(req_kind),
        .command(req_command), .address(req_address), .write_data(req_wdata),
        .ndata_bits(req_nbits), .dummy_cycles(req_dummy), .addr4_en(req_addr4),
        .quad_en(req_quad), .decode_done(decode_done), .tx_str(tx_str),
        .cmd_end(cmd_end), .addr_end(addr_end), .dummy_end(dummy_end),
        .total_cycles(total_cycles), .rx_active(rx_active), .quad_data(quad_data)
    );

    spi_sclk_gen #(.CLKS_PER_HALF_SCLK(CLKS_PER_HALF_SCLK)) sclk_gen_i (
        .clk(clk), .rst(rst), .sclk_en(sclk_en), .xfer_start(xfer_start),
        .total_cycles(total_cycles), .sclk(sclk), .lead_edge(lead_edge),
        .trail_edge(trail_edge), .cycle_count(cycle_count), .xfer_done(xfer_done)
    );

    spi_shift_engine shift_i (
        .clk(clk), .rst(rst), .xfer_start(xfer_start), .lead_edge(lead_edge),
        .trail_edge(trail_edge), .cycle_count(cycle_count), .tx_str(tx_str),
        .cmd_end(cmd_end), .addr_end(addr_end), .dummy_end(dummy_end),
        .quad_data(quad_data), .rx_active(rx_active), .dq_in(dq_in),
        .dq_out(dq_out), .dq_oe(lane_oe), .rx_bits(rx_bits)
    );

    spi_read_collector collector_i (
        .clk(clk), .rst(rst), .xfer_done(xfer_done), .rx_active(rx_active),
        .ndata_bits(req_nbits), .rx_bits(rx_bits), .read_data(read_data)
    );

endmodule

// File: verification/spi_flash_master_asserts.sv
`timescale 1ns/1ps

module spi_flash_master_asserts (
    input logic       clk,
    input logic       rst,
    input logic       sclk,
    input logic       ss_n,
    input logic [3:0] dq_oe,
    input logic       tready
);

    // Serial clock parks low between frames
    sclk_idle_low: assert property (@(posedge clk) disable iff (rst) ss_n |-> !sclk)
        else $error("sclk high while ss_n is high");

    lanes_released: assert property (@(posedge clk) disable iff (rst)
                                     ss_n |-> dq_oe == 4'b0000)
        else $error("dq_oe active while ss_n is high");

    // No request taken while a frame runs
    busy_not_ready: assert property (@(posedge clk) disable iff (rst) !ss_n |-> !tready)
        else $error("tready high while ss_n is low");

endmodule

bind spi_flash_master spi_flash_master_asserts asserts_i (
    .clk(clk),
    .rst(rst),
    .sclk(sclk),
    .ss_n(ss_n),
    .dq_oe(dq_oe),
    .tready(tready)
);

// File: verification/tb_spi_flash_master.sv
`timescale 1ns/1ps

module tb_spi_flash_master;
    import spi_cfg_pkg::*;
    import spi_frame_pkg::*;

    localparam int NROWS = 8;

    logic                    clk, rst, valid, tready, done, sclk, ss_n, addr4_en, quad_en;
    logic [FRAME_KIND_W-1:0] frame_kind;
    logic [CMD_W-1:0]        command;
    logic [ADDR_W-1:0]       address;
    logic [DATA_W-1:0]       write_data, read_data;
    logic [NBITS_W-1:0]      ndata_bits;
    logic [DUMMY_W-1:0]      dummy_cycles;
    logic [3:0]              dq_out, dq_oe, dq_in;

    // One row of stimulus and expected values per frame
    logic [FRAME_KIND_W-1:0] kind_tab[NROWS];
    logic [CMD_W-1:0]        cmd_tab[NROWS];
    logic [ADDR_W-1:0]       addr_tab[NROWS];
    logic [DATA_W-1:0]       wdata_tab[NROWS];
    logic [DATA_W-1:0]       flash_tab[NROWS];
    logic                    a4_tab[NROWS];
    logic                    quad_tab[NROWS];
    int                      nbits_tab[NROWS];
    int                      dummy_tab[NROWS];
    int                      cycles_tab[NROWS];

    // Current frame as the flash model sees it
    int                      addr_bits, data_start, lanes, nbits;
    logic                    is_read, is_write;
    logic [DATA_W-1:0]       flash_word;
    int                      fall_cnt, rise_cnt, cap_n, frame_cnt, done_cnt;
    logic [127:0]            cap;
    integer                  seed;

    spi_flash_master dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] actual,
                               input logic [127:0] expected);
        if (actual !== expected)
            fail_run($sformatf("mismatch at %0t: %s is %0h, expected %0h",
                               $time, name, actual, expected));
    endtask

    task automatic set_row(input int i, input logic [2:0] kind, input logic [7:0] cmd,
                           input logic [31:0] addr, input int bits, input int dummy,
                           input logic a4, input logic quad, input logic [31:0] flash,
                           input int cycles);
        kind_tab[i] = kind;
        cmd_tab[i] = cmd;
        addr_tab[i] = addr;
        nbits_tab[i] = bits;
        dummy_tab[i] = dummy;
        a4_tab[i] = a4;
        quad_tab[i] = quad;
        flash_tab[i] = flash;
        cycles_tab[i] = cycles;
    endtask

    // First byte off the wire ends up in bits 7:0
    function automatic logic [DATA_W-1:0] wire_order(input logic [DATA_W-1:0] word,
                                                     input int bits);
        logic [DATA_W-1:0] res;
        int                k;
        res = '0;
        for (k = 0; k < 4; k++) begin
            if (8 * k < bits)
                res[8*k +: 8] = word[31-8*k -: 8];
        end
        return res;
    endfunction

    always @(negedge ss_n) begin
        fall_cnt = 0;
        rise_cnt = 0;
        cap = '0;
        cap_n = 0;
        frame_cnt = frame_cnt + 1;
    end

    // Flash model captures host bits on rising sclk
    always @(posedge sclk) begin
        if (!ss_n) begin
            rise_cnt = rise_cnt + 1;
            if (fall_cnt < 8 + addr_bits || (is_write && lanes == 1)) begin
                check_value("dq_oe", dq_oe, 4'b0001);
                cap = {cap[126:0], dq_out[0]};
                cap_n = cap_n + 1;
            end else if (is_write) begin
                check_value("dq_oe", dq_oe, 4'b1111);
                cap = {cap[123:0], dq_out};
                cap_n = cap_n + 4;
            end else begin
                check_value("dq_oe", dq_oe, 4'b0000);
            end
        end
    end

    // Read data goes out MSB first after each falling sclk
    always @(negedge sclk) begin
        int d;
        if (!ss_n) begin
            fall_cnt = fall_cnt + 1;
            d = fall_cnt - data_start;
            #1;
            if (is_read && d >= 0 && d * lanes < nbits)
                dq_in = (lanes == 4) ? flash_word[31-4*d -: 4] : {2'b00, flash_word[31-d], 1'b0};
            else
                dq_in = 4'b0000;
        end
    end

    always @(negedge clk) begin
        if (done === 1'b1)
            done_cnt = done_cnt + 1;
        if (rst === 1'b0) begin
            if (ss_n) begin
                check_value("sclk", sclk, 1'b0);
                check_value("dq_oe", dq_oe, 4'b0000);
            end else begin
                check_value("tready", tready, 1'b0);
            end
        end
    end

    initial begin
        int                r;
        int                n;
        logic [127:0]      exp_tx;
        logic [DATA_W-1:0] last_read;
        seed = 88;
        rst = 1'b1;
        valid = 1'b0;
        frame_kind = '0;
        command = '0;
        address = '0;
        write_data = '0;
        ndata_bits = '0;
        dummy_cycles = '0;
        addr4_en = 1'b0;
        quad_en = 1'b0;
        dq_in = 4'b0000;
        set_row(0, KIND_CMD, 8'h06, 32'h0, 0, 0, 1'b0, 1'b0, 32'h0, 8);
        set_row(1, KIND_CMD_ADDR, 8'h20, 32'h0012_3456, 0, 0, 1'b0, 1'b0, 32'h0, 32);
        set_row(2, KIND_ADDR_RD, 8'h0B, 32'h0000_1F00, 32, 8, 1'b0, 1'b0, 32'hA5C3_1E7B, 72);
        set_row(3, KIND_ADDR_WR, 8'h02, 32'h0040_0010, 16, 0, 1'b0, 1'b0, 32'h0, 48);
        set_row(4, KIND_CMD_WR, 8'h01, 32'h0, 8, 0, 1'b0, 1'b0, 32'h0, 16);
        set_row(5, KIND_CMD_ADDR, 8'hDC, 32'h8765_4321, 0, 0, 1'b1, 1'b0, 32'h0, 40);
        set_row(6, KIND_ADDR_RD, 8'h6B, 32'h00AB_CDEF, 24, 8, 1'b0, 1'b1, 32'h3C96_F00D, 46);
        set_row(7, KIND_ADDR_WR, 8'h32, 32'h0001_0200, 32, 0, 1'b0, 1'b1, 32'h0, 40);
        for (r = 0; r < NROWS; r++)
            wdata_tab[r] = $random(seed);
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;
        check_value("tready", tready, 1'b1);
        check_value("ss_n", ss_n, 1'b1);
        check_value("sclk", sclk, 1'b0);
        check_value("dq_oe", dq_oe, 4'b0000);
        check_value("done", done, 1'b0);
        check_value("read_data", read_data, '0);
        last_read = '0;
        for (r = 0; r < NROWS; r++) begin
            @(posedge clk);
            #1;
            is_read = (kind_tab[r] == KIND_ADDR_RD);
            is_write = (kind_tab[r] == KIND_CMD_WR) || (kind_tab[r] == KIND_ADDR_WR);
            if (kind_tab[r] == KIND_CMD || kind_tab[r] == KIND_CMD_WR)
                addr_bits = 0;
            else
                addr_bits = a4_tab[r] ? 32 : 24;
            lanes = quad_tab[r] ? 4 : 1;
            nbits = nbits_tab[r];
            data_start = 8 + addr_bits + (is_read ? dummy_tab[r] : 0);
            flash_word = flash_tab[r];
            frame_kind = kind_tab[r];
            command = cmd_tab[r];
            address = addr_tab[r];
            write_data = wdata_tab[r];
            ndata_bits = NBITS_W'(nbits_tab[r]);
            dummy_cycles = DUMMY_W'(dummy_tab[r]);
            addr4_en = a4_tab[r];
            quad_en = quad_tab[r];
            // Valid stays high for the whole frame
            valid = 1'b1;
            n = 0;
            do begin
                @(posedge clk);
                #1;
                n++;
                if (n > 2000)
                    fail_run($sformatf("timeout waiting for done on row %0d", r));
            end while (done !== 1'b1);
            valid = 1'b0;
            check_value("ss_n", ss_n, 1'b1);
            check_value("tready", tready, 1'b1);
            check_value("sclk cycles", rise_cnt, cycles_tab[r]);
            exp_tx = 128'(cmd_tab[r]);
            if (addr_bits > 0)
                exp_tx = (exp_tx << addr_bits) |
                         (128'(addr_tab[r]) & ((128'd1 << addr_bits) - 1));
            if (is_write)
                exp_tx = (exp_tx << nbits) | 128'(wdata_tab[r] >> (32 - nbits));
            check_value("tx bit count", cap_n, 8 + addr_bits + (is_write ? nbits : 0));
            check_value("tx bits", cap, exp_tx);
            if (is_read)
                last_read = wire_order(flash_tab[r], nbits);
            check_value("read_data", read_data, last_read);
            repeat (4) @(posedge clk);
            check_value("done count", done_cnt, r + 1);
            check_value("frame count", frame_cnt, r + 1);
        end
        $display("Test OK");
        $finish;
    end

endmodule

// File: sim.f
verilog/spi_cfg_pkg.sv
verilog/spi_frame_pkg.sv
verilog/spi_frame_decoder.sv
verilog/spi_sclk_gen.sv
verilog/spi_shift_engine.sv
verilog/spi_read_collector.sv
verilog/spi_flash_master.sv
verification/spi_flash_master_asserts.sv
verification/tb_spi_flash_master.sv

// File: Makefile
TOP := tb_spi_flash_master

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sim.f -o sim_bin
	./obj_dir/sim_bin | tee /dev/stderr | grep -qx "Test OK"

clean:
	rm -rf obj_dir
